//--- verilog/fridge_config.svh
// Timing, temperature limit and FIFO depth constants for the fridge controller.
// Include in any RTL file that needs them. Timer values are in clock cycles
// and are scaled down so a simulation run stays short.
`ifndef FRIDGE_CONFIG_SVH
`define FRIDGE_CONFIG_SVH

// ==================================================
// timing in clk cycles
// ==================================================
`define FRIDGE_SAMPLE_PERIOD    200     // between sample triggers
`define FRIDGE_INIT_DELAY       100     // settle time spent in init
`define FRIDGE_DEFROST_PERIOD   20000   // normal cycles between defrosts
`define FRIDGE_DEFROST_DURATION 3000    // heater on time
`define FRIDGE_DOOR_DELAY       2000    // door open before alarm
`define FRIDGE_COMP_GUARD       300     // anti short cycle hold off

// ==================================================
// temperatures in Q8.8
// ==================================================
`define FRIDGE_TEMP_DEFAULT     16'sh0400   // +4.0
`define FRIDGE_TEMP_MIN         16'shEC00   // -20.0
`define FRIDGE_TEMP_MAX         16'sh0A00   // +10.0
`define FRIDGE_TEMP_STEP        16'sh0080   // 0.5 per press

// over and under range limits
`define FRIDGE_ALARM_HIGH       16'sh0A00   // +10.0
`define FRIDGE_ALARM_LOW        16'shE700   // -25.0

// sample buffer between sampler and fsm
`define FRIDGE_FIFO_DEPTH       4

`endif

//--- verilog/fridge_pkg.sv
// Shared types of the fridge controller.
// Wishbone request/response bundles for the ADC, the sample word and the
// operating state encoding. Referenced by scoped name only.
package fridge_pkg;

    // signed Q8.8, 8 integer bits and 8 fraction bits
    typedef logic signed [15:0] temp_t;

    // ==================================================
    // ADC Wishbone classic, read only
    // ==================================================
    typedef struct packed {
        logic cyc;          // cycle in progress
        logic stb;          // strobe, same as cyc here
    } adc_wb_req_t;

    typedef struct packed {
        logic        ack;   // slave done
        logic [11:0] dat;   // raw adc code, valid with ack
    } adc_wb_rsp_t;

    // one converted sample
    typedef struct packed {
        temp_t temp;
    } sample_t;

    // operating states
    typedef enum logic [2:0] {
        INIT      = 3'd0,
        NORMAL    = 3'd1,
        DOOR_OPEN = 3'd2,
        DEFROST   = 3'd3,
        ALARM     = 3'd4
    } fridge_state_t;

endpackage

//--- verilog/sensor_sampler.sv
// Periodic temperature sampler.
// Issues a Wishbone classic read to the ADC every sample period, converts
// the 12-bit code to Q8.8 and pushes it into the sample FIFO.
`timescale 1ns/1ps
`include "fridge_config.svh"

module sensor_sampler (
    input  logic                    clk,
    input  logic                    rst_sync_d,
    output fridge_pkg::adc_wb_req_t adc_wb_req,
    input  fridge_pkg::adc_wb_rsp_t adc_wb_rsp,
    output logic                    push,
    output fridge_pkg::sample_t     push_data,
    input  logic                    full
);

    localparam int per_w = $clog2(`FRIDGE_SAMPLE_PERIOD);

    typedef enum logic [1:0] {
        s_idle,
        s_read,     // bus cycle open, waiting for ack
        s_hold      // sample converted, waiting for fifo room
    } seq_t;

    logic [per_w-1:0]    period_cnt;
    logic                trigger;
    seq_t                seq;
    logic signed [19:0]  conv_full;     // 25*adc - 51200, before the shift
    fridge_pkg::sample_t sample_q;

    // ==================================================
    // sample period
    // ==================================================
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            period_cnt <= '0;
        end else if (period_cnt == per_w'(`FRIDGE_SAMPLE_PERIOD - 1)) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign trigger = (period_cnt == '0);   // first one right after reset

    // ==================================================
    // read sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            seq <= s_idle;
        end else begin
            case (seq)
                s_idle:  if (trigger) seq <= s_read;        // else trigger dropped
                s_read:  if (adc_wb_rsp.ack) seq <= s_hold;
                s_hold:  if (!full) seq <= s_idle;          // push this cycle
                default: seq <= s_idle;
            endcase
        end
    end

    assign adc_wb_req.cyc = (seq == s_read);
    assign adc_wb_req.stb = (seq == s_read);    // never split from cyc

    // adc 2048 is 0.0 C, one code is 25/1024 C
    assign conv_full = $signed({8'd0, adc_wb_rsp.dat}) * 20'sd25 - 20'sd51200;

    // result held until the fifo takes it
    always_ff @(posedge clk) begin
        if (seq == s_read && adc_wb_rsp.ack) begin
            sample_q.temp <= conv_full[17:2];       // arithmetic >> 2
        end
    end

    assign push      = (seq == s_hold) && !full;
    assign push_data = sample_q;

endmodule

//--- verilog/sample_fifo.sv
// Small synchronous FIFO for temperature samples.
// Show-ahead read, push and pop may happen in the same cycle.
`timescale 1ns/1ps
`include "fridge_config.svh"

module sample_fifo #(
    parameter int depth = `FRIDGE_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_sync_d,
    input  logic                push,
    input  fridge_pkg::sample_t push_data,
    output logic                full,
    input  logic                pop,
    output fridge_pkg::sample_t pop_data,
    output logic                empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    fridge_pkg::sample_t mem [depth];
    logic [aw-1:0]       wr_ptr;
    logic [aw-1:0]       rd_ptr;
    logic [cw-1:0]       count;     // occupancy
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];          // head word, no pop needed
    assign full     = (count == cw'(depth));
    assign empty    = (count == '0);

endmodule

//--- verilog/panel_inputs.sv
// Front panel inputs.
// Synchronizes the buttons and door switch, detects button presses and
// keeps the user setpoint within limits.
`timescale 1ns/1ps
`include "fridge_config.svh"

module panel_inputs (
    input  logic              clk,
    input  logic              rst_sync_d,
    input  logic              button_up,
    input  logic              button_down,
    input  logic              button_mode,
    input  logic              door_sensor,
    output fridge_pkg::temp_t setpoint,
    output logic              door_open,
    output logic              ack_press
);

    // bit positions in the button vectors
    localparam int btn_up   = 0;
    localparam int btn_down = 1;
    localparam int btn_mode = 2;

    logic [2:0] btn_s1;     // first sync stage
    logic [2:0] btn_s2;     // second sync stage
    logic [2:0] btn_prev;   // for edge detect
    logic [2:0] press;

    // ==================================================
    // synchronizers
    // ==================================================
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            btn_s1    <= '0;
            btn_s2    <= '0;
            btn_prev  <= '0;
            door_open <= 1'b0;
        end else begin
            btn_s1    <= {button_mode, button_down, button_up};
            btn_s2    <= btn_s1;
            btn_prev  <= btn_s2;
            door_open <= door_sensor;   // slow switch, one stage
        end
    end

    assign press     = btn_s2 & ~btn_prev;  // rising edges only
    assign ack_press = press[btn_mode];

    // setpoint, up press has priority
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            setpoint <= `FRIDGE_TEMP_DEFAULT;
        end else if (press[btn_up]) begin
            if (setpoint < (`FRIDGE_TEMP_MAX - `FRIDGE_TEMP_STEP))
                setpoint <= setpoint + `FRIDGE_TEMP_STEP;
        end else if (press[btn_down]) begin
            if (setpoint > (`FRIDGE_TEMP_MIN + `FRIDGE_TEMP_STEP))
                setpoint <= setpoint - `FRIDGE_TEMP_STEP;
        end
    end

endmodule

//--- verilog/fridge_fsm.sv
// Operating state machine of the fridge controller.
// Latches samples from the FIFO, runs init/normal/door/defrost/alarm and
// drives compressor, heater, alarm and status LEDs with a compressor guard.
`timescale 1ns/1ps
`include "fridge_config.svh"

module fridge_fsm (
    input  logic                clk,
    input  logic                rst_sync_d,
    input  fridge_pkg::sample_t pop_data,
    input  logic                empty,
    output logic                pop,
    input  fridge_pkg::temp_t   setpoint,
    input  logic                door_open,
    input  logic                ack_press,
    output logic                compressor_on,
    output logic                defrost_heater,
    output logic                alarm,
    output logic [2:0]          status_led
);

    localparam int init_w  = $clog2(`FRIDGE_INIT_DELAY);
    localparam int dfr_max = (`FRIDGE_DEFROST_PERIOD > `FRIDGE_DEFROST_DURATION) ?
                             `FRIDGE_DEFROST_PERIOD : `FRIDGE_DEFROST_DURATION;
    localparam int dfr_w   = $clog2(dfr_max + 1);
    localparam int door_w  = $clog2(`FRIDGE_DOOR_DELAY);
    localparam int guard_w = $clog2(`FRIDGE_COMP_GUARD + 1);

    fridge_pkg::fridge_state_t state;
    fridge_pkg::fridge_state_t next_state;

    fridge_pkg::temp_t temp_q;          // last sample
    logic              temp_valid;
    logic [init_w-1:0] init_cnt;
    logic [dfr_w-1:0]  defrost_cnt;     // period in normal, duration in defrost
    logic [door_w-1:0] door_cnt;
    logic [guard_w-1:0] guard_cnt;
    logic              out_of_range;

    // ==================================================
    // sample latch
    // ==================================================
    assign pop = !empty;                // drain every sample

    always_ff @(posedge clk) begin
        if (pop) temp_q <= pop_data.temp;
    end

    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) temp_valid <= 1'b0;
        else if (pop)    temp_valid <= 1'b1;
    end

    assign out_of_range = temp_valid &&
                          ((temp_q > `FRIDGE_ALARM_HIGH) || (temp_q < `FRIDGE_ALARM_LOW));

    // ==================================================
    // state transitions
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            fridge_pkg::INIT:      if (init_cnt == '0) next_state = fridge_pkg::NORMAL;
            fridge_pkg::NORMAL: begin
                if (door_open)                next_state = fridge_pkg::DOOR_OPEN;
                else if (defrost_cnt == '0)   next_state = fridge_pkg::DEFROST;
                else if (out_of_range)        next_state = fridge_pkg::ALARM;
            end
            fridge_pkg::DOOR_OPEN: begin
                if (!door_open)               next_state = fridge_pkg::NORMAL;
                else if (door_cnt == '0)      next_state = fridge_pkg::ALARM;
            end
            fridge_pkg::DEFROST:   if (defrost_cnt == '0) next_state = fridge_pkg::NORMAL;
            fridge_pkg::ALARM:     if (ack_press) next_state = fridge_pkg::NORMAL;
            default:                          next_state = fridge_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) state <= fridge_pkg::INIT;
        else             state <= next_state;
    end

    // ==================================================
    // timers
    // ==================================================
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            init_cnt    <= init_w'(`FRIDGE_INIT_DELAY - 1);
            defrost_cnt <= dfr_w'(`FRIDGE_DEFROST_PERIOD);
            door_cnt    <= door_w'(`FRIDGE_DOOR_DELAY - 1);
            guard_cnt   <= guard_w'(`FRIDGE_COMP_GUARD);    // no start right after reset
        end else begin
            if (state == fridge_pkg::INIT && init_cnt != '0)
                init_cnt <= init_cnt - 1'b1;

            // defrost entry loads duration, exit reloads period
            if (state == fridge_pkg::NORMAL && next_state == fridge_pkg::DEFROST)
                defrost_cnt <= dfr_w'(`FRIDGE_DEFROST_DURATION - 1);
            else if (state == fridge_pkg::DEFROST && next_state == fridge_pkg::NORMAL)
                defrost_cnt <= dfr_w'(`FRIDGE_DEFROST_PERIOD);
            else if ((state == fridge_pkg::NORMAL || state == fridge_pkg::DEFROST) &&
                     defrost_cnt != '0)
                defrost_cnt <= defrost_cnt - 1'b1;

            if (state != fridge_pkg::DOOR_OPEN)
                door_cnt <= door_w'(`FRIDGE_DOOR_DELAY - 1);    // rearm when closed
            else if (door_cnt != '0)
                door_cnt <= door_cnt - 1'b1;

            // guard restarts at each switch-off
            if (guard_cnt != '0)
                guard_cnt <= guard_cnt - 1'b1;
            else if (compressor_on && temp_valid && (temp_q < setpoint))
                guard_cnt <= guard_w'(`FRIDGE_COMP_GUARD);
        end
    end

    // ==================================================
    // output drives
    // ==================================================
    always_ff @(posedge clk or negedge rst_sync_d) begin
        if (!rst_sync_d) begin
            compressor_on  <= 1'b0;
            defrost_heater <= 1'b0;
        end else begin
            case (state)
                fridge_pkg::NORMAL: begin
                    if (guard_cnt == '0)
                        compressor_on <= temp_valid && (temp_q > setpoint);
                    defrost_heater <= 1'b0;
                end
                fridge_pkg::DOOR_OPEN: ;        // hold as is
                fridge_pkg::DEFROST: begin
                    compressor_on  <= 1'b0;
                    defrost_heater <= 1'b1;
                end
                default: begin                  // init, alarm
                    compressor_on  <= 1'b0;
                    defrost_heater <= 1'b0;
                end
            endcase
        end
    end

    assign alarm         = (state == fridge_pkg::ALARM);
    assign status_led[0] = (state == fridge_pkg::NORMAL);    // green
    assign status_led[1] = (state == fridge_pkg::DEFROST);   // yellow
    assign status_led[2] = (state == fridge_pkg::ALARM);     // red

endmodule

//--- verilog/fridge_ctrl_top.sv
// Fridge temperature control core, top level.
// Sampler feeds the sample FIFO, the FSM drains it and drives the outputs.
// The ADC sits outside as a Wishbone classic slave.
`timescale 1ns/1ps

module fridge_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_sync_d,     // already synchronized
    output fridge_pkg::adc_wb_req_t adc_wb_req,
    input  fridge_pkg::adc_wb_rsp_t adc_wb_rsp,
    input  logic                    button_up,
    input  logic                    button_down,
    input  logic                    button_mode,
    input  logic                    door_sensor,
    output logic                    compressor_on,
    output logic                    defrost_heater,
    output logic                    alarm,
    output logic [2:0]              status_led
);

    // sampler to fifo
    logic                push;
    fridge_pkg::sample_t push_data;
    logic                full;

    // fifo to fsm
    logic                pop;
    fridge_pkg::sample_t pop_data;
    logic                empty;

    // panel to fsm
    fridge_pkg::temp_t   setpoint;
    logic                door_open;
    logic                ack_press;

    sensor_sampler u_sampler (
        .clk(clk), .rst_sync_d(rst_sync_d),
        .adc_wb_req(adc_wb_req), .adc_wb_rsp(adc_wb_rsp),
        .push(push), .push_data(push_data), .full(full)
    );

    sample_fifo u_fifo (
        .clk(clk), .rst_sync_d(rst_sync_d),
        .push(push), .push_data(push_data), .full(full),
        .pop(pop), .pop_data(pop_data), .empty(empty)
    );

    panel_inputs u_panel (
        .clk(clk), .rst_sync_d(rst_sync_d),
        .button_up(button_up), .button_down(button_down), .button_mode(button_mode),
        .door_sensor(door_sensor),
        .setpoint(setpoint), .door_open(door_open), .ack_press(ack_press)
    );

    fridge_fsm u_fsm (
        .clk(clk), .rst_sync_d(rst_sync_d),
        .pop_data(pop_data), .empty(empty), .pop(pop),
        .setpoint(setpoint), .door_open(door_open), .ack_press(ack_press),
        .compressor_on(compressor_on), .defrost_heater(defrost_heater),
        .alarm(alarm), .status_led(status_led)
    );

endmodule

//--- tb/fridge_props.sv
// Concurrent checks on the fridge control core.
// Bound into the top level; each failure is also counted for the testbench.
`timescale 1ns/1ps

module fridge_props (
    input logic                    clk,
    input logic                    rst_sync_d,
    input fridge_pkg::adc_wb_req_t adc_wb_req,
    input fridge_pkg::adc_wb_rsp_t adc_wb_rsp,
    input logic                    compressor_on,
    input logic                    defrost_heater,
    input logic                    alarm,
    input logic [2:0]              status_led
);

    int assert_fails = 0;       // read by the testbench at the end

    // ==================================================
    // wishbone request
    // ==================================================
    cyc_is_stb: assert property (@(posedge clk) disable iff (!rst_sync_d)
        adc_wb_req.cyc == adc_wb_req.stb)
        else begin $error("wishbone cyc and stb differ"); assert_fails++; end

    req_holds: assert property (@(posedge clk) disable iff (!rst_sync_d)
        adc_wb_req.cyc && !adc_wb_rsp.ack |=> adc_wb_req.cyc)
        else begin $error("wishbone request dropped before ack"); assert_fails++; end

    req_ends: assert property (@(posedge clk) disable iff (!rst_sync_d)
        adc_wb_req.cyc && adc_wb_rsp.ack |=> !adc_wb_req.cyc)
        else begin $error("wishbone request still up after ack"); assert_fails++; end

    // outputs
    no_heat_and_cool: assert property (@(posedge clk) disable iff (!rst_sync_d)
        !(compressor_on && defrost_heater))
        else begin $error("compressor and heater both on"); assert_fails++; end

    alarm_is_red: assert property (@(posedge clk) disable iff (!rst_sync_d)
        alarm == status_led[2])
        else begin $error("alarm and red LED differ"); assert_fails++; end

    one_led: assert property (@(posedge clk) disable iff (!rst_sync_d)
        $onehot0(status_led))
        else begin $error("more than one status LED lit"); assert_fails++; end

endmodule

bind fridge_ctrl_top fridge_props u_props (
    .clk(clk), .rst_sync_d(rst_sync_d),
    .adc_wb_req(adc_wb_req), .adc_wb_rsp(adc_wb_rsp),
    .compressor_on(compressor_on), .defrost_heater(defrost_heater),
    .alarm(alarm), .status_led(status_led)
);

//--- tb/fridge_tb.sv
// Directed testbench for the fridge control core.
// Models the ADC as a Wishbone classic slave with random wait states and
// steps the core through reset, cooling, setpoint, alarm, door and defrost.
`timescale 1ns/1ps
`include "fridge_config.svh"

module fridge_tb;

    localparam int sample_bound = 2 * `FRIDGE_SAMPLE_PERIOD + `FRIDGE_COMP_GUARD;
    localparam int run_cycles   = `FRIDGE_DEFROST_PERIOD + `FRIDGE_DEFROST_DURATION +
                                  `FRIDGE_DOOR_DELAY + 40 * `FRIDGE_SAMPLE_PERIOD;
    localparam int sig_green  = 0;      // probe selectors
    localparam int sig_yellow = 1;
    localparam int sig_red    = 2;
    localparam int sig_alarm  = 3;
    localparam int sig_comp   = 4;
    localparam int sig_heater = 5;
    localparam int btn_up     = 0;
    localparam int btn_down   = 1;
    localparam int btn_mode   = 2;

    logic                    clk;
    logic                    rst_sync_d;
    fridge_pkg::adc_wb_req_t adc_wb_req;
    fridge_pkg::adc_wb_rsp_t adc_wb_rsp;
    logic                    button_up;
    logic                    button_down;
    logic                    button_mode;
    logic                    door_sensor;
    logic                    compressor_on;
    logic                    defrost_heater;
    logic                    alarm;
    logic [2:0]              status_led;
    logic [11:0]             adc_code;      // what the adc model returns
    int                      error_count;
    int                      sp_model;      // expected setpoint, Q8.8

    initial clk = 1'b0;
    always #5 clk = ~clk;                   // 100 MHz

    fridge_ctrl_top uut (
        .clk(clk), .rst_sync_d(rst_sync_d),
        .adc_wb_req(adc_wb_req), .adc_wb_rsp(adc_wb_rsp),
        .button_up(button_up), .button_down(button_down), .button_mode(button_mode),
        .door_sensor(door_sensor),
        .compressor_on(compressor_on), .defrost_heater(defrost_heater),
        .alarm(alarm), .status_led(status_led)
    );

    // ==================================================
    // adc slave model, 0 to 3 wait cycles per read
    // ==================================================
    initial begin : adc_slave
        int unsigned wait_cycles;
        void'($urandom(32'hc605_d77a));     // single seed for the run
        adc_wb_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (adc_wb_req.cyc) begin
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                adc_wb_rsp.dat = adc_code;
                adc_wb_rsp.ack = 1'b1;      // one cycle ack
                @(posedge clk);
                #1;
                adc_wb_rsp = '0;
            end
        end
    end

    initial begin : watchdog
        repeat (run_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run never finished", run_cycles);
        $display("Errors found");
        $fatal(1, "watchdog timeout");
    end

    // ==================================================
    // helpers
    // ==================================================
    // inverse of (25*adc - 51200) >>> 2, rounded up
    function automatic logic [11:0] adc_for_temp(input int temp_q88);
        return 12'((temp_q88 * 4 + 51200 + 24) / 25);
    endfunction

    function automatic int temp_of_adc(input int adc);
        return (25 * adc - 51200) >>> 2;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            sig_green:  return status_led[0];
            sig_yellow: return status_led[1];
            sig_red:    return status_led[2];
            sig_alarm:  return alarm;
            sig_comp:   return compressor_on;
            sig_heater: return defrost_heater;
            default:    return 1'bx;
        endcase
    endfunction

    task automatic tick(input int n);       // always ends 1 ns after an edge
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string msg);
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %0t: %s, expected %0h, got %0h", $time, msg, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic wait_until(input int sel, input logic value, input int max_cycles,
                              input string what);
        int n;
        n = 0;
        while (probe(sel) !== value && n < max_cycles) begin
            tick(1);
            n++;
        end
        if (probe(sel) !== value) begin
            $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
            stop_on_error();
        end
    endtask

    task automatic set_temperature(input int temp_q88);
        adc_code = adc_for_temp(temp_q88);
    endtask

    // hold the pin 4 cycles, release 4, and track the setpoint rule
    task automatic press_button(input int which);
        button_up   = (which == btn_up);
        button_down = (which == btn_down);
        button_mode = (which == btn_mode);
        tick(4);
        button_up   = 1'b0;
        button_down = 1'b0;
        button_mode = 1'b0;
        tick(4);
        if (which == btn_up) begin
            if (sp_model < (`FRIDGE_TEMP_MAX - `FRIDGE_TEMP_STEP))
                sp_model += `FRIDGE_TEMP_STEP;
        end else if (which == btn_down) begin
            if (sp_model > (`FRIDGE_TEMP_MIN + `FRIDGE_TEMP_STEP))
                sp_model -= `FRIDGE_TEMP_STEP;
        end
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset();
        tick(5);
        check(0, {compressor_on, defrost_heater, alarm, status_led, adc_wb_req},
              "outputs during reset");
        tick(5);
        rst_sync_d = 1'b1;                  // released after 10 edges
        check(0, {compressor_on, defrost_heater, alarm, status_led, adc_wb_req},
              "outputs right after reset");
        wait_until(sig_green, 1'b1, `FRIDGE_INIT_DELAY + 5, "green LED after init");
    endtask

    task automatic test_cooling();
        set_temperature(6 * 256);
        wait_until(sig_comp, 1'b1, sample_bound, "compressor on at 6.0 C");
        check(temp_of_adc(adc_code), uut.u_fsm.temp_q, "latched temperature at 6.0 C");
        set_temperature(2 * 256);
        wait_until(sig_comp, 1'b0, sample_bound, "compressor off at 2.0 C");
    endtask

    task automatic test_setpoint();
        set_temperature(3 * 256);
        tick(2 * `FRIDGE_SAMPLE_PERIOD);
        check(0, compressor_on, "compressor at 3.0 C, default setpoint");
        repeat (3) press_button(btn_down);
        check(2 * 256 + 128, uut.setpoint, "setpoint after three down presses");
        wait_until(sig_comp, 1'b1, sample_bound, "compressor on with setpoint 2.5 C");
        repeat (16) press_button(btn_up);   // runs into the upper limit
        check(sp_model, uut.setpoint, "setpoint held at upper limit");
        set_temperature(9 * 256);
        wait_until(sig_comp, 1'b0, sample_bound, "compressor off at 9.0 C");
        tick(2 * `FRIDGE_SAMPLE_PERIOD);
        check(0, compressor_on, "compressor stays off at 9.0 C");
    endtask

    task automatic test_alarm();
        set_temperature(11 * 256);
        wait_until(sig_red, 1'b1, 2 * `FRIDGE_SAMPLE_PERIOD, "red LED at 11.0 C");
        tick(1);
        check(1, alarm, "alarm at 11.0 C");
        check(0, compressor_on, "compressor in alarm");
        set_temperature(4 * 256);
        tick(2 * `FRIDGE_SAMPLE_PERIOD);    // let the in-range sample land
        check(1, alarm, "alarm held until acknowledge");
        press_button(btn_mode);
        wait_until(sig_green, 1'b1, 10, "green LED after acknowledge");
        check(0, alarm, "alarm cleared by acknowledge");
    endtask

    task automatic test_door();
        door_sensor = 1'b1;
        repeat (100) begin
            tick(1);
            check(0, alarm, "alarm during short door opening");
        end
        check(0, status_led, "no LED with door open");
        door_sensor = 1'b0;
        wait_until(sig_green, 1'b1, 5, "green LED after door closed");
        door_sensor = 1'b1;
        wait_until(sig_alarm, 1'b1, `FRIDGE_DOOR_DELAY + 10, "alarm with door left open");
        door_sensor = 1'b0;
        tick(2);
        check(1, alarm, "door alarm held after door closed");
        press_button(btn_mode);
        wait_until(sig_green, 1'b1, 10, "green LED after door alarm acknowledge");
    endtask

    task automatic test_defrost();
        check(1, status_led[0], "normal state before defrost");
        set_temperature(9 * 256 + 192);     // above setpoint 9.5 yet below alarm
        wait_until(sig_comp, 1'b1, sample_bound, "compressor on at 9.75 C");
        wait_until(sig_yellow, 1'b1, `FRIDGE_DEFROST_PERIOD, "defrost start");
        tick(1);
        check(1, defrost_heater, "heater in defrost");
        check(0, compressor_on, "compressor in defrost");
        wait_until(sig_green, 1'b1, `FRIDGE_DEFROST_DURATION + 5, "end of defrost");
        wait_until(sig_heater, 1'b0, 1, "heater off after defrost");
    endtask

    initial begin
        error_count = 0;
        sp_model    = `FRIDGE_TEMP_DEFAULT;
        rst_sync_d  = 1'b0;
        button_up   = 1'b0;
        button_down = 1'b0;
        button_mode = 1'b0;
        door_sensor = 1'b0;
        adc_code    = adc_for_temp(3 * 256);    // below default setpoint
        test_reset();
        test_cooling();
        test_setpoint();
        test_alarm();
        test_door();
        test_defrost();
        check(0, uut.u_props.assert_fails, "concurrent assertion failures");
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- fridge_ctrl.f
+incdir+verilog
verilog/fridge_pkg.sv
verilog/sensor_sampler.sv
verilog/sample_fifo.sv
verilog/panel_inputs.sv
verilog/fridge_fsm.sv
verilog/fridge_ctrl_top.sv
tb/fridge_props.sv
tb/fridge_tb.sv

//--- Bender.yml
package:
  name: fridge_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fridge_pkg.sv
      - verilog/sensor_sampler.sv
      - verilog/sample_fifo.sv
      - verilog/panel_inputs.sv
      - verilog/fridge_fsm.sv
      - verilog/fridge_ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/fridge_props.sv
      - tb/fridge_tb.sv
